// ==== design/isa_pkg.sv ====
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_index_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // Major opcodes of the two register/immediate groups
    localparam opcode_t OPCODE_OP     = 7'b0110011;
    localparam opcode_t OPCODE_OP_IMM = 7'b0010011;

    localparam funct3_t F3_ADD_SUB     = 3'b000;
    localparam funct3_t F3_SLL         = 3'b001;
    localparam funct3_t F3_SLT         = 3'b010;
    localparam funct3_t F3_SLTU        = 3'b011;
    localparam funct3_t F3_XOR         = 3'b100;
    localparam funct3_t F3_SHIFT_RIGHT = 3'b101;
    localparam funct3_t F3_OR          = 3'b110;
    localparam funct3_t F3_AND         = 3'b111;

    localparam int ALT_BIT = 30;        // Sub and arithmetic shift select

    localparam int NUM_REGS = 32;

    localparam word_t INSTR_BYTES = 32'd4;

endpackage

// ==== design/core_pkg.sv ====
package core_pkg;
    import isa_pkg::*;
    export isa_pkg::*;

    localparam int NUM_STATIONS = 4;

    localparam logic [1:0] MEM_SIZE_WORD = 2'd2;

    typedef logic [$clog2(NUM_STATIONS)-1:0] tag_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_OR,
        ALU_AND,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLTU,
        ALU_SLT
    } alu_op_t;

    // Known value when ready, otherwise waiting on tag
    typedef struct packed {
        logic  ready;
        tag_t  tag;
        word_t value;
    } operand_t;

    typedef struct packed {
        logic       legal;
        alu_op_t    op;
        logic       use_imm;
        word_t      imm;            // Already sign-extended
        reg_index_t dest;
    } decoded_t;

    typedef struct packed {
        logic       valid;
        tag_t       tag;
        reg_index_t dest;
        word_t      value;
    } result_t;

endpackage

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu
    import core_pkg::*;
(
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   y
);

    logic [4:0] shamt;

    assign shamt = b[4:0];      // Upper bits ignored

    always_comb begin
        case (op)
            ALU_ADD:  y = a + b;
            ALU_SUB:  y = a - b;
            ALU_OR:   y = a | b;
            ALU_AND:  y = a & b;
            ALU_XOR:  y = a ^ b;
            ALU_SLL:  y = a << shamt;
            ALU_SRL:  y = a >> shamt;
            ALU_SRA:  y = word_t'($signed(a) >>> shamt);
            ALU_SLTU: y = {31'b0, a < b};
            ALU_SLT:  y = {31'b0, $signed(a) < $signed(b)};
            default:  y = '0;
        endcase
    end

endmodule

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  memory_ready,
    input  word_t memory_data_in,
    input  logic  dispatch,
    output word_t memory_address,
    output logic  memory_enable,
    output logic  instr_valid,
    output word_t instr
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_MEM,
        HOLD
    } fetch_state_t;

    fetch_state_t state;
    word_t        pc;

    assign memory_address = pc;
    assign memory_enable  = (state == WAIT_MEM);   // Held until ready
    assign instr_valid    = (state == HOLD);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            pc    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (!memory_ready) begin      // Previous transfer fully closed
                        state <= WAIT_MEM;
                    end
                end
                WAIT_MEM: begin
                    if (memory_ready) begin
                        pc    <= pc + INSTR_BYTES;
                        state <= HOLD;
                    end
                end
                HOLD: begin
                    if (dispatch) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == WAIT_MEM && memory_ready) begin
            instr <= memory_data_in;
        end
    end

endmodule

// ==== design/instruction_decoder.sv ====
`timescale 1ns/1ps

module instruction_decoder
    import isa_pkg::*;
    import core_pkg::*;
(
    input  word_t    instr,
    output decoded_t decoded
);

    opcode_t opcode;
    funct3_t funct3;
    logic    alt;
    logic    is_op;
    logic    is_op_imm;

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign alt       = instr[ALT_BIT];
    assign is_op     = (opcode == OPCODE_OP);
    assign is_op_imm = (opcode == OPCODE_OP_IMM);

    always_comb begin
        decoded.legal   = is_op || is_op_imm;     // Full compare also checks low bits 11
        decoded.use_imm = is_op_imm;
        decoded.imm     = {{20{instr[31]}}, instr[31:20]};
        decoded.dest    = instr[11:7];
        decoded.op      = ALU_ADD;

        case (funct3)
            F3_ADD_SUB: begin
                // Immediate form has no subtract
                decoded.op = (is_op && alt) ? ALU_SUB : ALU_ADD;
            end
            F3_SLL: begin
                decoded.op = ALU_SLL;
            end
            F3_SLT: begin
                decoded.op = ALU_SLT;
            end
            F3_SLTU: begin
                decoded.op = ALU_SLTU;
            end
            F3_XOR: begin
                decoded.op = ALU_XOR;
            end
            F3_SHIFT_RIGHT: begin
                decoded.op = alt ? ALU_SRA : ALU_SRL;  // Both groups
            end
            F3_OR: begin
                decoded.op = ALU_OR;
            end
            F3_AND: begin
                decoded.op = ALU_AND;
            end
        endcase
    end

endmodule

// ==== design/register_status.sv ====
`timescale 1ns/1ps

module register_status
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  word_t    instr,
    input  logic     alloc,
    input  tag_t     dispatch_tag,
    input  result_t  result,
    output operand_t src1,
    output operand_t src2
);

    word_t               values [NUM_REGS];
    tag_t                tags [NUM_REGS];
    logic [NUM_REGS-1:0] pending;

    reg_index_t src1_index;
    reg_index_t src2_index;
    reg_index_t dest_index;

    assign src1_index = instr[19:15];
    assign src2_index = instr[24:20];
    assign dest_index = instr[11:7];

    function automatic operand_t lookup(reg_index_t index);
        operand_t entry;
        entry.ready = 1'b1;
        entry.tag   = tags[index];
        entry.value = values[index];
        if (index == '0) begin
            entry.value = '0;
        end else if (pending[index]) begin
            if (result.valid && result.tag == tags[index]) begin
                entry.value = result.value;           // Same-cycle bypass
            end else begin
                entry.ready = 1'b0;
            end
        end
        return entry;
    endfunction

    always_comb begin
        src1 = lookup(src1_index);
        src2 = lookup(src2_index);
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                values[i] <= '0;
                tags[i]   <= '0;
            end
            pending <= '0;
        end else begin
            // Only the newest producer may commit
            if (result.valid && pending[result.dest] && tags[result.dest] == result.tag) begin
                values[result.dest]  <= result.value;
                pending[result.dest] <= 1'b0;
            end
            if (alloc && dest_index != '0) begin    // Overrides a same-cycle commit
                pending[dest_index] <= 1'b1;
                tags[dest_index]    <= dispatch_tag;
            end
        end
    end

endmodule

// ==== design/reservation_stations.sv ====
`timescale 1ns/1ps

module reservation_stations
    import core_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     instr_valid,
    input  decoded_t decoded,
    input  operand_t src1,
    input  operand_t src2,
    output logic     dispatch,
    output logic     alloc,
    output tag_t     dispatch_tag,
    output result_t  result
);

    typedef struct packed {
        alu_op_t    op;
        reg_index_t dest;
        operand_t   a;
        operand_t   b;
    } station_t;

    logic [NUM_STATIONS-1:0] busy;
    station_t                stations [NUM_STATIONS];

    logic     free_found;
    logic     issue_found;
    tag_t     issue_tag;
    station_t issue_station;
    operand_t operand_b;
    word_t    alu_y;

    // Reverse scans leave the lowest index
    always_comb begin
        free_found   = 1'b0;
        dispatch_tag = '0;
        for (int i = NUM_STATIONS - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_found   = 1'b1;
                dispatch_tag = tag_t'(i);
            end
        end
    end

    always_comb begin
        issue_found = 1'b0;
        issue_tag   = '0;
        for (int i = NUM_STATIONS - 1; i >= 0; i--) begin
            if (busy[i] && stations[i].a.ready && stations[i].b.ready) begin
                issue_found = 1'b1;
                issue_tag   = tag_t'(i);
            end
        end
    end

    assign alloc    = instr_valid && decoded.legal && free_found;
    assign dispatch = instr_valid && (!decoded.legal || free_found);   // Illegal word dropped

    always_comb begin
        operand_b = src2;
        if (decoded.use_imm) begin
            operand_b.ready = 1'b1;
            operand_b.value = decoded.imm;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy <= '0;
        end else begin
            if (issue_found) begin
                busy[issue_tag] <= 1'b0;
            end
            if (alloc) begin                    // Never the issuing station
                busy[dispatch_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < NUM_STATIONS; i++) begin
            if (busy[i] && result.valid) begin
                if (!stations[i].a.ready && stations[i].a.tag == result.tag) begin
                    stations[i].a.ready <= 1'b1;
                    stations[i].a.value <= result.value;
                end
                if (!stations[i].b.ready && stations[i].b.tag == result.tag) begin
                    stations[i].b.ready <= 1'b1;
                    stations[i].b.value <= result.value;
                end
            end
        end
        if (alloc) begin
            stations[dispatch_tag].op   <= decoded.op;
            stations[dispatch_tag].dest <= decoded.dest;
            stations[dispatch_tag].a    <= src1;
            stations[dispatch_tag].b    <= operand_b;
        end
    end

    assign issue_station = stations[issue_tag];

    alu alu0 (
        .op (issue_station.op),
        .a  (issue_station.a.value),
        .b  (issue_station.b.value),
        .y  (alu_y)
    );

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            result <= '0;
        end else begin
            result.valid <= issue_found;        // One cycle per issue
            result.tag   <= issue_tag;
            result.dest  <= issue_station.dest;
            result.value <= alu_y;
        end
    end

endmodule

// ==== design/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core
    import core_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    output word_t      memory_address,
    input  word_t      memory_data_in,
    output word_t      memory_data_out,
    output logic [1:0] memory_data_size,
    output logic       memory_enable,
    output logic       memory_operation,
    input  logic       memory_ready,
    output result_t    result
);

    logic     instr_valid;
    word_t    instr;
    logic     dispatch;
    logic     alloc;
    tag_t     dispatch_tag;
    decoded_t decoded;
    operand_t src1;
    operand_t src2;

    // Instruction reads only
    assign memory_data_out  = '0;
    assign memory_data_size = MEM_SIZE_WORD;
    assign memory_operation = 1'b0;

    fetch_unit fetch0 (
        .clock          (clock),
        .reset          (reset),
        .memory_ready   (memory_ready),
        .memory_data_in (memory_data_in),
        .dispatch       (dispatch),
        .memory_address (memory_address),
        .memory_enable  (memory_enable),
        .instr_valid    (instr_valid),
        .instr          (instr)
    );

    instruction_decoder decoder0 (
        .instr   (instr),
        .decoded (decoded)
    );

    register_status status0 (
        .clock        (clock),
        .reset        (reset),
        .instr        (instr),
        .alloc        (alloc),
        .dispatch_tag (dispatch_tag),
        .result       (result),
        .src1         (src1),
        .src2         (src2)
    );

    reservation_stations stations0 (
        .clock        (clock),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .decoded      (decoded),
        .src1         (src1),
        .src2         (src2),
        .dispatch     (dispatch),
        .alloc        (alloc),
        .dispatch_tag (dispatch_tag),
        .result       (result)
    );

endmodule

// ==== tb/program_table.svh ====
// Each row holds the instruction word, whether it gives a result,
// the destination register and the expected value
`ifndef PROGRAM_TABLE_SVH
`define PROGRAM_TABLE_SVH

typedef struct packed {
    word_t      word;
    logic       has_result;
    reg_index_t dest;
    word_t      expected;
} program_row_t;

localparam int NUM_ROWS = 25;

localparam program_row_t PROGRAM [NUM_ROWS] = '{
    '{32'h00500093, 1'b1, 5'd1,  32'h00000005},     // addi x1, x0, 5
    '{32'hFFD00113, 1'b1, 5'd2,  32'hFFFFFFFD},     // addi x2, x0, -3
    '{32'h55504193, 1'b1, 5'd3,  32'h00000555},     // xori x3, x0, 0x555
    '{32'hF0006213, 1'b1, 5'd4,  32'hFFFFFF00},     // ori x4, x0, -256
    '{32'h7FF07293, 1'b1, 5'd5,  32'h00000000},     // andi x5, x0, 0x7ff
    '{32'hFFF02313, 1'b1, 5'd6,  32'h00000000},     // slti x6, x0, -1
    '{32'hFFF03393, 1'b1, 5'd7,  32'h00000001},     // sltiu x7, x0, -1
    '{32'h002084B3, 1'b1, 5'd9,  32'h00000002},     // add x9, x1, x2
    '{32'h40448533, 1'b1, 5'd10, 32'h00000102},     // sub x10, x9, x4
    '{32'h40125633, 1'b1, 5'd12, 32'hFFFFFFF8},     // sra x12, x4, x1
    '{32'h001256B3, 1'b1, 5'd13, 32'h07FFFFF8},     // srl x13, x4, x1
    '{32'h00500091, 1'b0, 5'd0,  32'h00000000},     // Low opcode bits 01 make it illegal
    '{32'h00D64733, 1'b1, 5'd14, 32'hF8000000},     // xor x14, x12, x13
    '{32'h001728B3, 1'b1, 5'd17, 32'h00000001},     // slt x17, x14, x1
    '{32'h00173933, 1'b1, 5'd18, 32'h00000000},     // sltu x18, x14, x1
    '{32'h40475993, 1'b1, 5'd19, 32'hFF800000},     // srai x19, x14, 4
    '{32'h00A09B33, 1'b1, 5'd22, 32'h00000014},     // sll x22, x1, x10 (0x102 shifts by 2)
    '{32'h40A75BB3, 1'b1, 5'd23, 32'hFE000000},     // sra x23, x14, x10
    '{32'h00148C13, 1'b1, 5'd24, 32'h00000003},     // addi x24, x9, 1
    '{32'h001C0CB3, 1'b1, 5'd25, 32'h00000008},     // add x25, x24, x1
    '{32'h001C9D13, 1'b1, 5'd26, 32'h00000010},     // slli x26, x25, 1
    '{32'h418D0DB3, 1'b1, 5'd27, 32'h0000000D},     // sub x27, x26, x24
    '{32'h01ADEE33, 1'b1, 5'd28, 32'h0000001D},     // or x28, x27, x26
    '{32'h002E5E93, 1'b1, 5'd29, 32'h00000007},     // srli x29, x28, 2
    '{32'h01BEFF33, 1'b1, 5'd30, 32'h00000005}      // and x30, x29, x27
};

`endif

// ==== tb/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb
    import isa_pkg::*;
    import core_pkg::*;
();

    `include "program_table.svh"

    localparam int   RESET_CYCLES    = 5;
    localparam int   WATCHDOG_CYCLES = (NUM_ROWS + 3) * 8 + RESET_CYCLES;   // Table plus drain
    localparam logic READ_OPERATION  = 1'b0;
    localparam logic [1:0] WORD_SIZE = 2'd2;

    logic       clock          = 1'b0;
    logic       reset          = 1'b1;
    logic       memory_ready   = 1'b0;
    word_t      memory_data_in = '0;
    word_t      memory_address;
    word_t      memory_data_out;
    logic [1:0] memory_data_size;
    logic       memory_enable;
    logic       memory_operation;
    result_t    result;

    logic [31:0] rand_state = 32'h275a2cc6;
    logic        request_seen = 1'b0;
    logic [1:0]  wait_cycles = '0;
    word_t       expected_address = '0;
    int          requests_served = 0;

    logic  dest_expected [NUM_REGS];
    int    result_count [NUM_REGS];
    word_t result_value [NUM_REGS];
    int    results_expected = 0;
    int    results_seen = 0;
    int    checks = 0;
    int    value_errors = 0;
    int    other_errors = 0;

    cpu_core dut0 (
        .clock            (clock),
        .reset            (reset),
        .memory_address   (memory_address),
        .memory_data_in   (memory_data_in),
        .memory_data_out  (memory_data_out),
        .memory_data_size (memory_data_size),
        .memory_enable    (memory_enable),
        .memory_operation (memory_operation),
        .memory_ready     (memory_ready),
        .result           (result)
    );

    initial begin
        forever #50 clock = ~clock;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t word_at(input word_t address);
        int index;
        index = int'(address[31:2]);
        if (index < NUM_ROWS) begin
            return PROGRAM[index].word;
        end
        return '0;              // Zero word past the table is illegal
    endfunction

    task automatic check_equal(input string name, input word_t expected, input word_t actual);
        checks++;
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_request();
        check_equal($sformatf("request %0d address", requests_served),
                    expected_address, memory_address);
        check_equal($sformatf("request %0d operation", requests_served),
                    {31'b0, READ_OPERATION}, {31'b0, memory_operation});
        check_equal($sformatf("request %0d size", requests_served),
                    {30'b0, WORD_SIZE}, {30'b0, memory_data_size});
        check_equal($sformatf("request %0d data out", requests_served),
                    32'h0, memory_data_out);
        expected_address = expected_address + 32'd4;
        requests_served++;
    endtask

    task automatic report_counts();
        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
    endtask

    // Memory answers after 0 to 3 idle cycles
    always @(posedge clock) begin
        if (reset) begin
            memory_ready <= 1'b0;
            request_seen <= 1'b0;
        end else if (memory_ready) begin
            if (!memory_enable) begin
                memory_ready <= 1'b0;
            end
        end else if (memory_enable) begin
            if (!request_seen) begin
                check_request();
                rand_state = xorshift(rand_state);
                if (rand_state[1:0] == 2'd0) begin
                    memory_ready   <= 1'b1;
                    memory_data_in <= word_at(memory_address);
                end else begin
                    request_seen <= 1'b1;
                    wait_cycles  <= rand_state[1:0] - 2'd1;
                end
            end else if (wait_cycles == 2'd0) begin
                memory_ready   <= 1'b1;
                memory_data_in <= word_at(memory_address);
                request_seen   <= 1'b0;
            end else begin
                wait_cycles <= wait_cycles - 2'd1;
            end
        end
    end

    always @(posedge clock) begin
        if (!reset && result.valid) begin
            if (!dest_expected[result.dest]) begin
                $display("Result for x%0d, which no table row writes", result.dest);
                other_errors++;
            end else if (result_count[result.dest] != 0) begin
                $display("More than one result for x%0d", result.dest);
                other_errors++;
            end else begin
                results_seen++;
            end
            result_count[result.dest]++;
            result_value[result.dest] = result.value;
        end
    end

    initial begin
        for (int r = 0; r < NUM_REGS; r++) begin
            dest_expected[r] = 1'b0;
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (PROGRAM[i].has_result) begin
                dest_expected[PROGRAM[i].dest] = 1'b1;
                results_expected++;
            end
        end
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;

        // Also run a few zero words past the table to catch stray results
        while (results_seen < results_expected || requests_served <= NUM_ROWS + 2) begin
            @(posedge clock);
        end
        @(posedge clock);

        for (int i = 0; i < NUM_ROWS; i++) begin
            if (PROGRAM[i].has_result) begin
                check_equal($sformatf("row %0d x%0d", i, PROGRAM[i].dest),
                            PROGRAM[i].expected, result_value[PROGRAM[i].dest]);
            end
        end

        report_counts();
        if (value_errors == 0 && other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Timeout: the program did not complete within %0d cycles", WATCHDOG_CYCLES);
        report_counts();
        $display("Something failed");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+tb
design/isa_pkg.sv
design/core_pkg.sv
design/alu.sv
design/fetch_unit.sv
design/instruction_decoder.sv
design/register_status.sv
design/reservation_stations.sv
design/cpu_core.sv
tb/cpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module cpu_tb -f files.f -o cpu_tb_sim
./obj_dir/cpu_tb_sim | tee sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished without failure"
